// ==== common/cpu16_isa_pkg.sv ====
package cpu16_isa_pkg;

	localparam int unsigned XLEN   = 16; // data path width
	localparam int unsigned REG_AW = 4;  // 16 registers

	// instruction class, top nibble of every word
	typedef enum logic [3:0] {
		NOP    = 4'h0,
		IMM    = 4'h1,
		ALU_RR = 4'h2,
		ALU_RI = 4'h3
	} insn_class_e;

	// codes 8..15 are reserved, decode drops them
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		MOV = 4'h7 // passes operand B
	} alu_op_e;

	// immediate prefix word
	typedef struct packed {
		insn_class_e cls;
		logic [11:0] prefix; // upper 12 bits of next immediate
	} imm_view_t;

	// ALU word, low field is imm[3:0] for ALU_RI and rs for ALU_RR
	typedef struct packed {
		insn_class_e        cls;
		alu_op_e            op;
		logic [REG_AW-1:0]  rd;
		logic [3:0]         low;
	} alu_view_t;

	typedef union packed {
		imm_view_t imm_view;
		alu_view_t alu_view;
	} cpu16_insn_u;

	typedef struct packed {
		logic c; // carry on ADD, borrow on SUB
		logic z;
		logic s;
	} alu_flags_t;

endpackage

// ==== common/cpu16_pipe_pkg.sv ====
package cpu16_pipe_pkg;

	import cpu16_isa_pkg::*;

	// APB read port, requester side
	typedef struct packed {
		logic [XLEN-1:0] paddr;
		logic            psel;
		logic            penable;
	} apb_req_t;

	// completer side
	typedef struct packed {
		logic [XLEN-1:0] prdata;
		logic            pready;
	} apb_rsp_t;

	// fetch -> decode
	typedef struct packed {
		logic        valid;
		cpu16_insn_u insn;
	} fetch_out_t;

	// decode -> execute
	typedef struct packed {
		logic              valid;
		alu_op_e           op;
		logic [REG_AW-1:0] rd;      // dest and operand A
		logic [REG_AW-1:0] rs;      // operand B register
		logic              use_imm;
		logic [XLEN-1:0]   imm;
	} decode_out_t;

	// execute -> write-back
	typedef struct packed {
		logic              valid;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   result;
		alu_flags_t        flags;
	} exec_out_t;

	// trace port shows the write-back record as is
	typedef exec_out_t reg_wr_t;

endpackage

// ==== fetch/fetch_apb.sv ====
module fetch_apb
	import cpu16_pipe_pkg::*;
#(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic       CLK,
	input  logic       RSTb,
	output apb_req_t   apb_req,
	input  apb_rsp_t   apb_rsp,
	output fetch_out_t fetch
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} fetch_state_e;

	fetch_state_e state;
	logic [15:0]  pc;
	logic         done; // transfer completes at this edge

	assign done = (state == ST_ACCESS) && apb_rsp.pready;

	// idle only right after reset, then setup/access back to back
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_IDLE;
			pc    <= RESET_PC;
		end else begin
			case (state)
				ST_IDLE:   state <= ST_SETUP;
				ST_SETUP:  state <= ST_ACCESS;
				ST_ACCESS: begin
					if (apb_rsp.pready)
						state <= ST_SETUP;
				end
				default:   state <= ST_IDLE;
			endcase
			if (done)
				pc <= pc + 16'd1;
		end
	end

	always_comb begin
		apb_req.paddr   = pc;
		apb_req.psel    = (state != ST_IDLE);
		apb_req.penable = (state == ST_ACCESS);
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			fetch.valid <= 1'b0;
		end else begin
			fetch.valid <= done; // one cycle pulse per instruction
			if (done)
				fetch.insn <= apb_rsp.prdata;
		end
	end

	// completer may stretch the access, request must hold meanwhile
	a_access_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(apb_req.penable && !apb_rsp.pready) |=>
			($stable(apb_req.paddr) && apb_req.psel && apb_req.penable));

endmodule

// ==== core/decode_stage.sv ====
module decode_stage
	import cpu16_isa_pkg::*;
	import cpu16_pipe_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  fetch_out_t  fetch,
	output decode_out_t dec
);

	cpu16_insn_u insn;
	logic [11:0] prefix_q; // upper immediate from a preceding IMM
	logic        is_imm;
	logic        is_alu;
	logic        op_ok;

	assign insn = fetch.insn;

	// same word read through both views
	assign is_imm = (insn.imm_view.cls == IMM);
	assign is_alu = (insn.alu_view.cls == ALU_RR) || (insn.alu_view.cls == ALU_RI);
	assign op_ok  = !insn.alu_view.op[3]; // 8..15 unused

	// prefix lives for exactly one following instruction
	always_ff @(posedge CLK) begin
		if (!RSTb)
			prefix_q <= 12'h000;
		else if (fetch.valid)
			prefix_q <= is_imm ? insn.imm_view.prefix : 12'h000;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= fetch.valid && is_alu && op_ok;
			if (fetch.valid) begin
				dec.op      <= insn.alu_view.op;
				dec.rd      <= insn.alu_view.rd;
				dec.rs      <= insn.alu_view.low;
				dec.use_imm <= (insn.alu_view.cls == ALU_RI);
				dec.imm     <= {prefix_q, insn.alu_view.low};
			end
		end
	end

endmodule

// ==== core/execute_stage.sv ====
module execute_stage
	import cpu16_isa_pkg::*;
	import cpu16_pipe_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  decode_out_t dec,
	output logic [3:0]  rd_addr_a,
	output logic [3:0]  rd_addr_b,
	input  logic [15:0] rd_data_a,
	input  logic [15:0] rd_data_b,
	output exec_out_t   ex
);

	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [XLEN:0]   wide;   // extra bit catches carry / borrow
	logic [XLEN-1:0] result;
	alu_flags_t      flags;

	// operands straight from the register file, no forwarding needed
	assign rd_addr_a = dec.rd;
	assign rd_addr_b = dec.rs;

	assign opa = rd_data_a;
	assign opb = dec.use_imm ? dec.imm : rd_data_b;

	always_comb begin
		wide = '0;
		case (dec.op)
			ADD:     wide = {1'b0, opa} + {1'b0, opb};
			SUB:     wide = {1'b0, opa} - {1'b0, opb};
			AND:     wide = {1'b0, opa & opb};
			OR:      wide = {1'b0, opa | opb};
			XOR:     wide = {1'b0, opa ^ opb};
			SHL:     wide = {1'b0, opa << opb[3:0]}; // shift by low nibble
			SHR:     wide = {1'b0, opa >> opb[3:0]};
			MOV:     wide = {1'b0, opb};
			default: wide = '0;
		endcase
	end

	assign result  = wide[XLEN-1:0];
	assign flags.c = wide[XLEN] && ((dec.op == ADD) || (dec.op == SUB));
	assign flags.z = (result == '0);
	assign flags.s = result[XLEN-1];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ex.valid <= 1'b0;
		end else begin
			ex.valid <= dec.valid;
			if (dec.valid) begin
				ex.rd     <= dec.rd;
				ex.result <= result;
				ex.flags  <= flags;
			end
		end
	end

	// fetch needs two cycles per word, so the previous write has landed
	a_no_hazard: assert property (@(posedge CLK) disable iff (!RSTb)
		dec.valid |=> !dec.valid);

endmodule

// ==== core/writeback_regfile.sv ====
module writeback_regfile
	import cpu16_pipe_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [3:0]  rd_addr_a,
	input  logic [3:0]  rd_addr_b,
	output logic [15:0] rd_data_a,
	output logic [15:0] rd_data_b,
	input  exec_out_t   ex,
	output reg_wr_t     wr
);

	logic [15:0] regs [16];

	// architectural state, all registers start at zero
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 16'h0000;
		end else if (ex.valid) begin
			regs[ex.rd] <= ex.result;
		end
	end

	assign rd_data_a = regs[rd_addr_a]; // async read ports
	assign rd_data_b = regs[rd_addr_b];

	// trace mirrors the write committed at this same edge
	always_ff @(posedge CLK) begin
		if (!RSTb)
			wr.valid <= 1'b0;
		else
			wr <= ex;
	end

	// traced value must be what the array now holds
	a_trace_src: assert property (@(posedge CLK) disable iff (!RSTb)
		wr.valid |-> ($past(ex.valid) && (regs[wr.rd] == wr.result)));

endmodule

// ==== src/cpu16_top.sv ====
module cpu16_top
	import cpu16_pipe_pkg::*;
#(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic     CLK,
	input  logic     RSTb,
	output apb_req_t apb_req,
	input  apb_rsp_t apb_rsp,
	output reg_wr_t  wr
);

	fetch_out_t  fetch;
	decode_out_t dec;
	exec_out_t   ex;
	logic [3:0]  rd_addr_a;
	logic [3:0]  rd_addr_b;
	logic [15:0] rd_data_a;
	logic [15:0] rd_data_b;

	fetch_apb #(
		.RESET_PC (RESET_PC)
	) fetch_i (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.fetch   (fetch)
	);

	decode_stage decode_i (
		.CLK   (CLK),
		.RSTb  (RSTb),
		.fetch (fetch),
		.dec   (dec)
	);

	execute_stage execute_i (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.dec       (dec),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.ex        (ex)
	);

	writeback_regfile regfile_i (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.ex        (ex),
		.wr        (wr)
	);

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK,
	output logic RSTb
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// released on a falling edge, like every other DUT input
	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
	end

endmodule

// ==== tests/tb_cpu16.sv ====
module tb_cpu16
	import cpu16_isa_pkg::*;
	import cpu16_pipe_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          CLK_PERIOD = 40;
	localparam logic [15:0] RESET_PC   = 16'h0100;

	logic        CLK;
	logic        RSTb;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	reg_wr_t     wr;
	logic [23:0] cases_mem [0:127]; // counts, program, expected writes
	integer      seed;
	int          n_words;
	int          n_trace;
	int          n_seen;
	int          fetch_count;
	int          cyc;
	int          pass_count;
	int          fail_count;
	int          errors;
	int          land_q [$]; // cycle at which each write must show up
	logic [1:0]  wait_left;
	bit          fetch_bad;
	bit          loaded;
	bit          load_bad;

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clock_i (.CLK(CLK), .RSTb(RSTb));

	cpu16_top #(.RESET_PC(RESET_PC)) dut_i (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.wr      (wr)
	);

	task automatic report_test(input string name, input bit ok);
		$display("%-7s %s", ok ? "ok" : "failed", name);
		if (ok)
			pass_count++;
		else
			fail_count++;
	endtask

	task automatic check_fetch(input apb_req_t got, input logic [15:0] exp_addr);
		if (got.paddr !== exp_addr) begin
			$display("** Error at %0t ns: apb_req.paddr = %h, expected %h",
				$time, got.paddr, exp_addr);
			errors++;
			fetch_bad = 1'b1;
		end
	endtask

	task automatic check_write(input reg_wr_t got, input reg_wr_t exp);
		if (got.rd !== exp.rd) begin
			$display("** Error at %0t ns: wr.rd = %h, expected %h", $time, got.rd, exp.rd);
			errors++;
		end
		if (got.result !== exp.result) begin
			$display("** Error at %0t ns: wr.result = %h, expected %h",
				$time, got.result, exp.result);
			errors++;
		end
		if (got.flags !== exp.flags) begin
			$display("** Error at %0t ns: wr.flags = %b, expected %b",
				$time, got.flags, exp.flags);
			errors++;
		end
	endtask

	function automatic reg_wr_t expected_write(input int k);
		logic [23:0] e;
		reg_wr_t     w;
		e = cases_mem[2 + n_words + k];
		w.valid  = 1'b1;
		w.rd     = e[23:20];
		w.result = e[19:4];
		w.flags  = e[2:0]; // c z s
		return w;
	endfunction

	function automatic logic [15:0] program_word(input logic [15:0] paddr);
		logic [15:0] idx;
		idx = paddr - RESET_PC;
		if (idx < n_words)
			return cases_mem[2 + idx][15:0];
		return 16'h0000; // nop beyond the program
	endfunction

	// ALU classes 2 and 3 with op codes 0..7 write a register
	function automatic bit writes_register(input logic [15:0] word);
		return (word[15:12] == 4'h2 || word[15:12] == 4'h3) && !word[11];
	endfunction

	always @(negedge CLK) begin : apb_and_trace
		logic [31:0] r;
		logic [15:0] word;
		int          errs_before;
		int          land;
		reg_wr_t     exp;
		cyc++;
		if (wr.valid === 1'b1) begin
			if (n_seen >= n_trace || land_q.size() == 0) begin
				$display("unexpected write to r%0d at %0t ns", wr.rd, $time);
				errors++;
				fail_count++;
			end else begin
				errs_before = errors;
				exp = expected_write(n_seen);
				check_write(wr, exp);
				land = land_q.pop_front();
				if (cyc != land) begin
					$display("write %0d landed in cycle %0d instead of cycle %0d",
						n_seen, cyc, land);
					errors++;
				end
				report_test($sformatf("write %0d to r%0d", n_seen, exp.rd), errors == errs_before);
				n_seen++;
			end
		end
		if (apb_req.psel && !apb_req.penable) begin
			r = $random(seed);
			wait_left = r[1:0]; // 0..3 wait cycles
			apb_rsp.pready = 1'b0;
		end else if (apb_req.psel && apb_req.penable && wait_left == 0) begin
			word = program_word(apb_req.paddr);
			check_fetch(apb_req, RESET_PC + fetch_count[15:0]);
			apb_rsp.prdata = word;
			apb_rsp.pready = 1'b1;
			if (writes_register(word))
				land_q.push_back(cyc + 4); // edge E+3, seen at the next falling edge
			fetch_count++;
		end else begin
			if (apb_req.psel && apb_req.penable)
				wait_left--;
			apb_rsp.pready = 1'b0;
		end
	end

	initial begin
		@(posedge RSTb);
		if (apb_req.psel !== 1'b0 || wr.valid !== 1'b0)
			$display("** Error at %0t ns: apb_req.psel = %b, wr.valid = %b, expected 0 and 0",
				$time, apb_req.psel, wr.valid);
		report_test("reset state", apb_req.psel === 1'b0 && wr.valid === 1'b0);
	end

	initial begin
		wait (loaded);
		#((n_words + 10) * 6 * CLK_PERIOD);
		$display("watchdog expired, trace did not complete (%0d of %0d writes seen)",
			n_seen, n_trace);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		$timeformat(-9, 0, "", 0);
		apb_rsp = '0;
		seed = 37;
		wait_left = 2'd0;
		$readmemh("tests/cpu16_cases.txt", cases_mem);
		load_bad = $isunknown(cases_mem[0]) || $isunknown(cases_mem[1]);
		if (load_bad) begin
			$display("cases file tests/cpu16_cases.txt could not be read");
			fail_count++;
		end else begin
			n_words = cases_mem[0];
			n_trace = cases_mem[1];
			loaded = 1'b1;
			wait (fetch_count > n_words);
			repeat (6) @(negedge CLK); // let the last words drain
			report_test($sformatf("fetch addresses over %0d transfers", fetch_count), !fetch_bad);
			if (n_seen != n_trace || land_q.size() != 0)
				$display("expected %0d writes, saw %0d", n_trace, n_seen);
			report_test("trace length", n_seen == n_trace && land_q.size() == 0);
		end
		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tests/cpu16_cases.txt ====
// line 1: number of program words, number of expected writes
// program words from address 0100, then writes as rd, result(4), flags {c,z,s}
1C 12
// program
0000 3715 1123 3724 3734 2012 2113
2212 2413 2313 2513 2613 2741 2812
5123 1FFF 375F 3051 3161 2166 2011
1ABC 0000 3787 1ABC 2791 F000 2F12
// expected write trace
100050 212340 300040 112390 112350 112340
112300 112340 123400 102340 402340 5FFFF1
500006 6FFFF5 600002 104680 800070 904680

// ==== tb.f ====
common/cpu16_isa_pkg.sv
common/cpu16_pipe_pkg.sv
fetch/fetch_apb.sv
core/decode_stage.sv
core/execute_stage.sv
core/writeback_regfile.sv
src/cpu16_top.sv
tests/tb_clock.sv
tests/tb_cpu16.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - common/cpu16_isa_pkg.sv
  - common/cpu16_pipe_pkg.sv
  - fetch/fetch_apb.sv
  - core/decode_stage.sv
  - core/execute_stage.sv
  - core/writeback_regfile.sv
  - src/cpu16_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_cpu16.sv
